/* include/dot_defines.svh */
`ifndef DOT_DEFINES_SVH
`define DOT_DEFINES_SVH

// Element and memory geometry.
`define DOT_ELEM_W      16
`define DOT_LANES       4
`define DOT_ADDR_W      10
`define DOT_MEM_DEPTH   1024
`define DOT_ACC_W       32

// AXI4-Lite bus widths.
`define DOT_AXI_ADDR_W  8
`define DOT_AXI_DATA_W  32

// Register map, one 32-bit word per register.
`define DOT_REG_CTRL      8'h00   // Bit 0 starts the engine.
`define DOT_REG_STATUS    8'h04   // Bit 0 busy, bit 1 done.
`define DOT_REG_A_BASE    8'h08
`define DOT_REG_B_BASE    8'h0C
`define DOT_REG_C_BASE    8'h10
`define DOT_REG_COUNT     8'h14   // Number of four-element groups.
`define DOT_REG_MEM_ADDR  8'h18
`define DOT_REG_MEM_DATA  8'h1C   // Auto-incrementing element window.

`endif

/* design/dot_pkg.sv */
`include "dot_defines.svh"

package dot_pkg;

    typedef logic [`DOT_ELEM_W-1:0]            elem_t;
    typedef logic [`DOT_ADDR_W-1:0]            addr_t;
    typedef logic [`DOT_LANES*`DOT_ELEM_W-1:0] lanes_t;      // Lane 0 in the low bits.
    typedef logic [`DOT_LANES-1:0]             lane_mask_t;
    typedef logic signed [`DOT_ACC_W-1:0]      acc_t;        // Signed, so products extend.

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_FETCH,
        ST_ACCUMULATE,
        ST_STORE
    } engine_state_t;

endpackage

/* design/mem_port_if.sv */
// One requester's view of a shared four-lane memory port.
interface mem_port_if;

    logic                req;
    logic                gnt;      // Same-cycle grant, that cycle is the access.
    dot_pkg::addr_t      addr;
    dot_pkg::lane_mask_t we;
    dot_pkg::lanes_t     wdata;
    dot_pkg::lanes_t     rdata;    // Valid the cycle after a read grant.

    modport requester (
        output req, addr, we, wdata,
        input  gnt, rdata
    );

    modport arbiter (
        input  req, addr, we, wdata,
        output gnt, rdata
    );

endinterface

/* design/lane_ram.sv */
`include "dot_defines.svh"

module lane_ram (
    input  logic                clk,
    input  dot_pkg::addr_t      addr0,
    input  dot_pkg::lane_mask_t we0,
    input  dot_pkg::lanes_t     d0,
    output dot_pkg::lanes_t     q0,
    input  dot_pkg::addr_t      addr1,
    output dot_pkg::lanes_t     q1
);

    dot_pkg::elem_t mem [`DOT_MEM_DEPTH];

    // Port 0, per-lane write plus registered read.
    always_ff @(posedge clk) begin
        for (int i = 0; i < `DOT_LANES; i++) begin
            if (we0[i]) begin
                mem[addr0 + dot_pkg::addr_t'(i)] <= d0[i*`DOT_ELEM_W +: `DOT_ELEM_W];
            end
            q0[i*`DOT_ELEM_W +: `DOT_ELEM_W] <= mem[addr0 + dot_pkg::addr_t'(i)];
        end
    end

    // Port 1 is read only.
    always_ff @(posedge clk) begin
        for (int i = 0; i < `DOT_LANES; i++) begin
            q1[i*`DOT_ELEM_W +: `DOT_ELEM_W] <= mem[addr1 + dot_pkg::addr_t'(i)];  // Wraps.
        end
    end

endmodule

/* design/mem_arbiter.sv */
module mem_arbiter (
    input  logic                clk,
    input  logic                rst,
    mem_port_if.arbiter         host,
    mem_port_if.arbiter         eng,
    output dot_pkg::addr_t      addr0,
    output dot_pkg::lane_mask_t we0,
    output dot_pkg::lanes_t     d0,
    input  dot_pkg::lanes_t     q0
);

    logic last_eng;  // Engine held the last grant.

    // On a tie, the side that did not win last time goes first.
    assign host.gnt = host.req & (~eng.req | last_eng);
    assign eng.gnt  = eng.req & (~host.req | ~last_eng);

    always_comb begin
        if (eng.gnt) begin
            addr0 = eng.addr;
            we0   = eng.we;
            d0    = eng.wdata;
        end else begin
            addr0 = host.addr;
            we0   = host.gnt ? host.we : '0;  // No write without a grant.
            d0    = host.wdata;
        end
    end

    // Both sides see the port-0 read data, only the granted one uses it.
    assign host.rdata = q0;
    assign eng.rdata  = q0;

    always_ff @(posedge clk) begin
        if (rst) begin
            last_eng <= 1'b0;
        end else if (eng.gnt) begin
            last_eng <= 1'b1;
        end else if (host.gnt) begin
            last_eng <= 1'b0;
        end
    end

endmodule

/* design/axil_regs.sv */
`include "dot_defines.svh"

module axil_regs (
    input  logic                         clk,
    input  logic                         rst,
    input  logic [`DOT_AXI_ADDR_W-1:0]   awaddr,
    input  logic                         awvalid,
    output logic                         awready,
    input  logic [`DOT_AXI_DATA_W-1:0]   wdata,
    input  logic [`DOT_AXI_DATA_W/8-1:0] wstrb,
    input  logic                         wvalid,
    output logic                         wready,
    output logic [1:0]                   bresp,
    output logic                         bvalid,
    input  logic                         bready,
    input  logic [`DOT_AXI_ADDR_W-1:0]   araddr,
    input  logic                         arvalid,
    output logic                         arready,
    output logic [`DOT_AXI_DATA_W-1:0]   rdata,
    output logic [1:0]                   rresp,
    output logic                         rvalid,
    input  logic                         rready,
    mem_port_if.requester                mem,
    output logic                         start,
    output dot_pkg::addr_t               a_base,
    output dot_pkg::addr_t               b_base,
    output dot_pkg::addr_t               c_base,
    output dot_pkg::addr_t               count,
    input  logic                         busy,
    input  logic                         done
);

    dot_pkg::addr_t                mem_addr;
    dot_pkg::elem_t                mem_wdata;
    logic                          mem_req;
    logic                          mem_rd;
    logic                          rd_wait;     // Memory read data arrives this cycle.
    logic                          mem_busy;
    logic                          wr_accept;
    logic                          rd_accept;
    logic [`DOT_AXI_DATA_W-1:0]    reg_rdata;

    // Byte strobes applied to a ten-bit register.
    function automatic dot_pkg::addr_t merge(dot_pkg::addr_t old, logic [31:0] data,
                                             logic [3:0] strb);
        dot_pkg::addr_t res;
        res = old;
        if (strb[0]) res[7:0] = data[7:0];
        if (strb[1]) res[9:8] = data[9:8];
        return res;
    endfunction

    // One window access at a time, writes win a same-cycle tie.
    assign mem_busy  = mem_req | rd_wait;
    assign wr_accept = awvalid & wvalid & ~bvalid & ~mem_busy;
    assign rd_accept = arvalid & ~rvalid & ~mem_busy & ~wr_accept;
    assign awready   = wr_accept;
    assign wready    = wr_accept;
    assign arready   = rd_accept;
    assign bresp     = 2'b00;
    assign rresp     = 2'b00;
    assign start     = wr_accept && awaddr == `DOT_REG_CTRL && wstrb[0] && wdata[0];

    assign mem.req   = mem_req;
    assign mem.addr  = mem_addr;
    assign mem.we    = (mem_req && !mem_rd) ? dot_pkg::lane_mask_t'(1) : '0;  // Lane 0 only.
    assign mem.wdata = dot_pkg::lanes_t'(mem_wdata);

    always_comb begin
        case (araddr)
            `DOT_REG_STATUS:   reg_rdata = `DOT_AXI_DATA_W'({done, busy});
            `DOT_REG_A_BASE:   reg_rdata = `DOT_AXI_DATA_W'(a_base);
            `DOT_REG_B_BASE:   reg_rdata = `DOT_AXI_DATA_W'(b_base);
            `DOT_REG_C_BASE:   reg_rdata = `DOT_AXI_DATA_W'(c_base);
            `DOT_REG_COUNT:    reg_rdata = `DOT_AXI_DATA_W'(count);
            `DOT_REG_MEM_ADDR: reg_rdata = `DOT_AXI_DATA_W'(mem_addr);
            default:           reg_rdata = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            a_base   <= '0;
            b_base   <= '0;
            c_base   <= '0;
            count    <= '0;
            mem_addr <= '0;
            mem_req  <= 1'b0;
            rd_wait  <= 1'b0;
            bvalid   <= 1'b0;
            rvalid   <= 1'b0;
        end else begin
            if (bvalid && bready) bvalid <= 1'b0;
            if (rvalid && rready) rvalid <= 1'b0;
            if (wr_accept) begin
                case (awaddr)
                    `DOT_REG_A_BASE:   a_base   <= merge(a_base, wdata, wstrb);
                    `DOT_REG_B_BASE:   b_base   <= merge(b_base, wdata, wstrb);
                    `DOT_REG_C_BASE:   c_base   <= merge(c_base, wdata, wstrb);
                    `DOT_REG_COUNT:    count    <= merge(count, wdata, wstrb);
                    `DOT_REG_MEM_ADDR: mem_addr <= merge(mem_addr, wdata, wstrb);
                    `DOT_REG_MEM_DATA: mem_req  <= 1'b1;
                    default: ;
                endcase
                if (awaddr != `DOT_REG_MEM_DATA) bvalid <= 1'b1;
            end
            if (rd_accept) begin
                if (araddr == `DOT_REG_MEM_DATA) mem_req <= 1'b1;
                else                             rvalid  <= 1'b1;
            end
            if (mem_req && mem.gnt) begin
                mem_req  <= 1'b0;
                mem_addr <= mem_addr + 1'b1;  // Auto-increment.
                if (mem_rd) rd_wait <= 1'b1;
                else        bvalid  <= 1'b1;
            end
            if (rd_wait) begin
                rd_wait <= 1'b0;
                rvalid  <= 1'b1;
            end
        end
    end

    // Payload registers.
    always_ff @(posedge clk) begin
        if (wr_accept) begin
            mem_rd    <= 1'b0;
            mem_wdata <= {wstrb[1] ? wdata[15:8] : 8'h00, wstrb[0] ? wdata[7:0] : 8'h00};
        end else if (rd_accept) begin
            mem_rd <= 1'b1;
        end
        if (rd_accept) rdata <= reg_rdata;
        if (rd_wait)   rdata <= `DOT_AXI_DATA_W'(mem.rdata[`DOT_ELEM_W-1:0]);  // Lane 0.
    end

endmodule

/* design/dot_engine.sv */
`include "dot_defines.svh"

module dot_engine (
    input  logic            clk,
    input  logic            rst,
    input  logic            start,
    input  dot_pkg::addr_t  a_base,
    input  dot_pkg::addr_t  b_base,
    input  dot_pkg::addr_t  c_base,
    input  dot_pkg::addr_t  count,
    output logic            busy,
    output logic            done,
    mem_port_if.requester   mem,
    output dot_pkg::addr_t  b_addr,
    input  dot_pkg::lanes_t b_rdata
);

    dot_pkg::engine_state_t state;
    dot_pkg::addr_t         idx;       // Current group.
    dot_pkg::acc_t          acc_q;
    dot_pkg::acc_t          prod_sum;
    logic                   gap;       // Idle cycle after a store.
    logic                   last;

    assign last   = (idx == count);
    assign b_addr = b_base + (idx << 2);  // Port 1 reads B alongside the A grant.

    assign mem.req   = (state == dot_pkg::ST_FETCH && !gap && !last) ||
                       (state == dot_pkg::ST_STORE);
    assign mem.addr  = (state == dot_pkg::ST_STORE) ? c_base + idx : a_base + (idx << 2);
    assign mem.we    = (state == dot_pkg::ST_STORE) ? dot_pkg::lane_mask_t'(1) : '0;
    assign mem.wdata = dot_pkg::lanes_t'(acc_q[`DOT_ELEM_W-1:0]);  // Low half to lane 0.

    // Four signed lane products summed.
    always_comb begin
        prod_sum = '0;
        for (int i = 0; i < `DOT_LANES; i++) begin
            prod_sum = prod_sum + $signed(mem.rdata[i*`DOT_ELEM_W +: `DOT_ELEM_W]) *
                                  $signed(b_rdata[i*`DOT_ELEM_W +: `DOT_ELEM_W]);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= dot_pkg::ST_IDLE;
            idx   <= '0;
            busy  <= 1'b0;
            done  <= 1'b0;
            gap   <= 1'b0;
        end else begin
            gap <= 1'b0;
            case (state)
                dot_pkg::ST_IDLE: begin
                    if (start) begin  // Start while busy never reaches here.
                        state <= dot_pkg::ST_FETCH;
                        idx   <= '0;
                        busy  <= 1'b1;
                        done  <= 1'b0;
                    end
                end
                dot_pkg::ST_FETCH: begin
                    if (!gap && last) begin
                        state <= dot_pkg::ST_IDLE;
                        busy  <= 1'b0;
                        done  <= 1'b1;
                    end else if (mem.gnt) begin
                        state <= dot_pkg::ST_ACCUMULATE;
                    end
                end
                dot_pkg::ST_ACCUMULATE: state <= dot_pkg::ST_STORE;  // Read data cycle.
                dot_pkg::ST_STORE: begin
                    if (mem.gnt) begin
                        idx   <= idx + 1'b1;
                        gap   <= 1'b1;
                        state <= dot_pkg::ST_FETCH;
                    end
                end
                default: state <= dot_pkg::ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == dot_pkg::ST_ACCUMULATE) acc_q <= prod_sum;
    end

endmodule

/* design/dot_accel_top.sv */
`include "dot_defines.svh"

module dot_accel_top (
    input  logic                         clk,
    input  logic                         rst,
    input  logic [`DOT_AXI_ADDR_W-1:0]   awaddr,
    input  logic                         awvalid,
    output logic                         awready,
    input  logic [`DOT_AXI_DATA_W-1:0]   wdata,
    input  logic [`DOT_AXI_DATA_W/8-1:0] wstrb,
    input  logic                         wvalid,
    output logic                         wready,
    output logic [1:0]                   bresp,
    output logic                         bvalid,
    input  logic                         bready,
    input  logic [`DOT_AXI_ADDR_W-1:0]   araddr,
    input  logic                         arvalid,
    output logic                         arready,
    output logic [`DOT_AXI_DATA_W-1:0]   rdata,
    output logic [1:0]                   rresp,
    output logic                         rvalid,
    input  logic                         rready,
    output logic                         done
);

    dot_pkg::addr_t      a_base;
    dot_pkg::addr_t      b_base;
    dot_pkg::addr_t      c_base;
    dot_pkg::addr_t      count;
    dot_pkg::addr_t      addr0;
    dot_pkg::addr_t      b_addr;
    dot_pkg::lane_mask_t we0;
    dot_pkg::lanes_t     d0;
    dot_pkg::lanes_t     q0;
    dot_pkg::lanes_t     b_rdata;
    logic                start;
    logic                busy;

    mem_port_if host_mem ();
    mem_port_if eng_mem ();

    axil_regs regs_i (
        .clk, .rst, .awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
        .bresp, .bvalid, .bready, .araddr, .arvalid, .arready, .rdata, .rresp,
        .rvalid, .rready, .mem(host_mem.requester), .start, .a_base, .b_base,
        .c_base, .count, .busy, .done
    );

    dot_engine engine_i (
        .clk, .rst, .start, .a_base, .b_base, .c_base, .count, .busy, .done,
        .mem(eng_mem.requester), .b_addr, .b_rdata
    );

    mem_arbiter arb_i (
        .clk, .rst, .host(host_mem.arbiter), .eng(eng_mem.arbiter),
        .addr0, .we0, .d0, .q0
    );

    // Port 1 belongs to the engine's B fetch.
    lane_ram ram_i (
        .clk, .addr0, .we0, .d0, .q0, .addr1(b_addr), .q1(b_rdata)
    );

endmodule

/* verification/dot_accel_sva.sv */
`include "dot_defines.svh"

module dot_accel_sva (
    input logic                       clk,
    input logic                       rst,
    input logic                       bvalid,
    input logic                       bready,
    input logic                       rvalid,
    input logic                       rready,
    input logic [`DOT_AXI_DATA_W-1:0] rdata,
    input logic                       host_gnt,
    input logic                       eng_gnt,
    input dot_pkg::lane_mask_t        we0
);

    bvalid_hold: assert property (@(posedge clk) disable iff (rst)
        bvalid && !bready |=> bvalid)
        else $error("bvalid dropped before bready");

    // Read data must not move while the master stalls.
    rvalid_hold: assert property (@(posedge clk) disable iff (rst)
        rvalid && !rready |=> rvalid && $stable(rdata))
        else $error("rvalid or rdata changed before rready");

    one_grant: assert property (@(posedge clk) disable iff (rst)
        !(host_gnt && eng_gnt))
        else $error("Host and engine granted in the same cycle");

    no_stray_write: assert property (@(posedge clk) disable iff (rst)
        !(host_gnt || eng_gnt) |-> we0 == '0)
        else $error("Port 0 write enable set without a grant");

endmodule

bind dot_accel_top dot_accel_sva sva_i (
    .clk, .rst, .bvalid, .bready, .rvalid, .rready, .rdata,
    .host_gnt(host_mem.gnt), .eng_gnt(eng_mem.gnt), .we0
);

/* verification/dot_accel_tb.sv */
`include "dot_defines.svh"

module dot_accel_tb;

    localparam int MAX_CMDS = 64;
    localparam int OP_END   = 0;
    localparam int OP_WRITE = 1;
    localparam int OP_READ  = 2;
    localparam int OP_WAIT  = 3;

    logic                         clk;
    logic                         rst;
    logic [`DOT_AXI_ADDR_W-1:0]   awaddr;
    logic                         awvalid;
    logic                         awready;
    logic [`DOT_AXI_DATA_W-1:0]   wdata;
    logic [`DOT_AXI_DATA_W/8-1:0] wstrb;
    logic                         wvalid;
    logic                         wready;
    logic [1:0]                   bresp;
    logic                         bvalid;
    logic                         bready;
    logic [`DOT_AXI_ADDR_W-1:0]   araddr;
    logic                         arvalid;
    logic                         arready;
    logic [`DOT_AXI_DATA_W-1:0]   rdata;
    logic [1:0]                   rresp;
    logic                         rvalid;
    logic                         rready;
    logic                         done;

    logic [31:0] cmd_mem [3*MAX_CMDS];  // Op, address, data per command.
    int          n_cmds;
    int          cycles;
    int          cycle_limit;
    int          errors;
    int          checks;
    int          seed;

    dot_accel_top dut_i (
        .clk, .rst, .awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
        .bresp, .bvalid, .bready, .araddr, .arvalid, .arready, .rdata, .rresp,
        .rvalid, .rready, .done
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycle_limit > 0 && cycles > cycle_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("Checks: %0d, errors: %0d", checks, errors);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    function automatic int rand_below(int n);
        return int'($unsigned($random(seed)) % 32'(n));
    endfunction

    // Called on a falling edge, returns on one.
    task automatic axi_write(logic [7:0] addr, logic [31:0] data);
        awaddr  = addr;
        wdata   = data;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        do @(posedge clk); while (!awready);  // Accepted at this edge.
        checks++;
        assert (wready == 1'b1) else begin
            errors++;
            $display("ERROR at %0t: wready expected 1, got %0b", $time, wready);
        end
        @(negedge clk);
        awvalid = 1'b0;
        wvalid  = 1'b0;
        while (!bvalid) @(negedge clk);
        // A start clears done at the edge that raises bvalid.
        if (addr == `DOT_REG_CTRL && data[0]) begin
            checks++;
            assert (done == 1'b0) else begin
                errors++;
                $display("ERROR at %0t: done expected 0, got %0b after start", $time, done);
            end
        end
        checks++;
        assert (bresp == 2'b00) else begin
            errors++;
            $display("ERROR at %0t: bresp expected 0, got %0d", $time, bresp);
        end
        repeat (rand_below(3)) @(negedge clk);  // Back-pressure.
        bready = 1'b1;
        @(posedge clk);
        @(negedge clk);
        bready = 1'b0;
    endtask

    task automatic axi_read_check(logic [7:0] addr, logic [31:0] exp);
        araddr  = addr;
        arvalid = 1'b1;
        do @(posedge clk); while (!arready);
        @(negedge clk);
        arvalid = 1'b0;
        while (!rvalid) @(negedge clk);
        repeat (rand_below(3)) @(negedge clk);
        checks += 2;
        assert (rdata == exp) else begin
            errors++;
            $display("ERROR at %0t: rdata from 0x%02h expected 0x%08h, got 0x%08h",
                     $time, addr, exp, rdata);
        end
        assert (rresp == 2'b00) else begin
            errors++;
            $display("ERROR at %0t: rresp expected 0, got %0d", $time, rresp);
        end
        rready = 1'b1;
        @(posedge clk);
        @(negedge clk);
        rready = 1'b0;
    endtask

    initial begin
        clk         = 1'b0;
        rst         = 1'b1;
        awaddr      = '0;
        awvalid     = 1'b0;
        wdata       = '0;
        wstrb       = '1;
        wvalid      = 1'b0;
        bready      = 1'b0;
        araddr      = '0;
        arvalid     = 1'b0;
        rready      = 1'b0;
        seed        = 32'hd1a83709;
        errors      = 0;
        checks      = 0;
        cycles      = 0;
        cycle_limit = 0;
        n_cmds      = 0;
        $readmemh("verification/dot_accel_testdata.mem", cmd_mem);
        while (n_cmds < MAX_CMDS && cmd_mem[3*n_cmds] != OP_END) n_cmds++;
        cycle_limit = (n_cmds + 1) * 200;  // End line counts too.
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        for (int k = 0; k < n_cmds; k++) begin
            repeat (rand_below(4)) @(negedge clk);  // Idle gap.
            case (cmd_mem[3*k])
                OP_WRITE: axi_write(cmd_mem[3*k+1][7:0], cmd_mem[3*k+2]);
                OP_READ:  axi_read_check(cmd_mem[3*k+1][7:0], cmd_mem[3*k+2]);
                OP_WAIT: begin
                    while (done !== 1'b1) @(negedge clk);
                end
                default: begin
                    errors++;
                    $display("Command %0d has an unknown operation code %0h", k, cmd_mem[3*k]);
                end
            endcase
        end
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

/* verification/dot_accel_testdata.mem */
// Columns: op (1 write, 2 read and expect, 3 wait for done, 0 end), AXI address, data.
// MEM_DATA reads return lane 0 zero-extended.
2 04 00000000   // STATUS clear after reset.
1 08 00000010   // A_BASE
1 0C 00000018   // B_BASE
1 10 00000080   // C_BASE
1 14 00000002   // COUNT, two groups.
2 08 00000010
2 0C 00000018
2 10 00000080
2 14 00000002
1 18 00000010   // Window at A group 0.
1 1C 00000003   // A0 = 3, -2, 256, 32767.
1 1C 0000FFFE
1 1C 00000100
1 1C 00007FFF
1 1C 00008000   // A1 = -32768, 16, -1, 4.
1 1C 00000010
1 1C 0000FFFF
1 1C 00000004
1 1C 00000005   // B0 = 5, 7, 512, 2.
1 1C 00000007
1 1C 00000200
1 1C 00000002
1 1C 00000003   // B1 = 3, -16, 4660, 17.
1 1C 0000FFF0
1 1C 00001234
1 1C 00000011
1 18 00000010   // Rewind the window.
2 1C 00000003
2 1C 0000FFFE
2 18 00000012   // Two reads stepped the address.
1 18 00000014
1 00 00000001   // Start.
2 1C 00008000   // Host reads while the engine runs.
2 1C 00000010
2 1C 0000FFFF
3 00 00000000
2 04 00000002   // Done, not busy.
1 18 00000080
2 1C 0000FFFF   // 15 - 14 + 131072 + 65534 = 0x2FFFF.
2 1C 00006D10   // -98304 - 256 - 4660 + 68 = -103152.
1 14 00000000   // Zero count run.
1 00 00000001
3 00 00000000
2 04 00000002
1 18 00000080
2 1C 0000FFFF   // C0 left as it was.
0 00 00000000

/* vlog.f */
+incdir+include
design/dot_pkg.sv
design/mem_port_if.sv
design/lane_ram.sv
design/mem_arbiter.sv
design/axil_regs.sv
design/dot_engine.sv
design/dot_accel_top.sv
verification/dot_accel_sva.sv
verification/dot_accel_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the dot-product testbench with Verilator from the project root.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module dot_accel_tb -f vlog.f -o dot_accel_sim \
    > build.log 2>&1 || { echo "Build failed, see build.log"; exit 1; }
./obj_dir/dot_accel_sim > sim.log 2>&1
grep -q "SIMULATION FAILED" sim.log && { echo "Test failed, see sim.log"; exit 1; }
grep -q "SIMULATION PASSED" sim.log || { echo "No pass line in sim.log"; exit 1; }
echo "Test passed"
